// File: verilog/side_ch_consts.svh
// side channel constants: bus widths, event count and frame control field positions
`ifndef SIDE_CH_CONSTS_SVH
`define SIDE_CH_CONSTS_SVH

// register bus
`define SIDE_CH_DATA_WIDTH 32
`define SIDE_CH_ADDR_WIDTH 5

// event counters
`define SIDE_CH_COUNTER_WIDTH 16
`define SIDE_CH_NUM_EVENTS 6

// event n takes its source select from bit n*stride of the select register
`define SIDE_CH_SEL_STRIDE 4

// rssi in half dB steps, signed
`define SIDE_CH_RSSI_WIDTH 11

// mac address and frame control type field
`define SIDE_CH_MAC_WIDTH 48
`define SIDE_CH_FC_TYPE_LSB 2

`endif

// File: verilog/side_ch_event_pkg.sv
// side channel event package: frame type, event source select and counter value types
`default_nettype none

`include "side_ch_consts.svh"

package side_ch_event_pkg;

	// type field of the 802.11 frame control word
	typedef enum logic [1:0]
	{
		frame_mgmt = 2'b00,
		frame_ctrl = 2'b01,
		frame_data = 2'b10,
		frame_ext  = 2'b11
	} frame_type_e;

	// per event choice between the two status sources
	typedef enum logic
	{
		src_primary   = 1'b0,
		src_alternate = 1'b1
	} event_src_e;

	// one wrapping event counter
	typedef logic [`SIDE_CH_COUNTER_WIDTH-1:0] counter_t;

endpackage

`default_nettype wire

// File: verilog/side_ch_reg_pkg.sv
// side channel register package: register address opcodes and register word type
`default_nettype none

`include "side_ch_consts.svh"

package side_ch_reg_pkg;

	// word addresses on the host register bus
	typedef enum logic [`SIDE_CH_ADDR_WIDTH-1:0]
	{
		reg_addr2_target    = 5'd7,
		reg_addr2_target_hi = 5'd8,
		reg_rssi_th         = 5'd9,
		reg_event_sel       = 5'd19,
		reg_counter0        = 5'd26,
		reg_counter1        = 5'd27,
		reg_counter2        = 5'd28,
		reg_counter3        = 5'd29,
		reg_counter4        = 5'd30,
		reg_counter5        = 5'd31
	} reg_addr_e;

	typedef logic [`SIDE_CH_DATA_WIDTH-1:0] reg_data_t;

endpackage

`default_nettype wire

// File: verilog/side_ch_event_decode.sv
// event decode: turns receiver and transmitter status strobes into six selected event pulses
`default_nettype none
`timescale 1ns/100ps

`include "side_ch_consts.svh"

module side_ch_event_decode
	import side_ch_event_pkg::*;
(
	input wire clk,
	input wire reset,

	// receiver status
	input wire short_preamble_detected,
	input wire long_preamble_detected,
	input wire pkt_header_valid_strobe,
	input wire pkt_header_valid,
	input wire fcs_in_strobe,
	input wire fcs_ok,
	input wire [`SIDE_CH_DATA_WIDTH-1:0] fc_di,
	input wire [`SIDE_CH_MAC_WIDTH-1:0] addr2,
	input wire pkt_for_me,
	input wire signed [`SIDE_CH_RSSI_WIDTH-1:0] rssi_half_db,

	// transmitter status
	input wire phy_tx_start,
	input wire tx_pkt_need_ack,
	input wire phy_tx_done,

	// configuration
	input wire [`SIDE_CH_NUM_EVENTS-1:0] event_sel,
	input wire [`SIDE_CH_MAC_WIDTH-1:0] addr2_target,
	input wire signed [`SIDE_CH_RSSI_WIDTH-1:0] rssi_th,

	output logic [`SIDE_CH_NUM_EVENTS-1:0] events
);

	frame_type_e frame_type;
	logic is_data;
	logic addr2_match;
	logic rssi_above;
	logic rssi_above_q;
	logic rssi_rise;
	logic [`SIDE_CH_NUM_EVENTS-1:0] ev_primary;
	logic [`SIDE_CH_NUM_EVENTS-1:0] ev_alternate;
	logic [`SIDE_CH_NUM_EVENTS-1:0] ev_next;

	assign frame_type = frame_type_e'(fc_di[`SIDE_CH_FC_TYPE_LSB +: $bits(frame_type_e)]);
	assign is_data = (frame_type == frame_data);
	assign addr2_match = (addr2 == addr2_target);

	// signed compare, then rising edge against last cycle
	assign rssi_above = (rssi_half_db > rssi_th);
	assign rssi_rise = rssi_above & ~rssi_above_q;

	assign ev_primary[0] = short_preamble_detected;
	assign ev_alternate[0] = long_preamble_detected;
	assign ev_primary[1] = pkt_header_valid_strobe & pkt_header_valid;
	assign ev_alternate[1] = pkt_header_valid_strobe & ~pkt_header_valid;
	assign ev_primary[2] = fcs_in_strobe & fcs_ok;
	assign ev_alternate[2] = fcs_in_strobe & ~fcs_ok;
	// good data frames from the target transmitter, or good frames for us
	assign ev_primary[3] = fcs_in_strobe & fcs_ok & is_data & addr2_match;
	assign ev_alternate[3] = fcs_in_strobe & fcs_ok & pkt_for_me;
	assign ev_primary[4] = phy_tx_start;
	assign ev_alternate[4] = phy_tx_start & tx_pkt_need_ack;
	assign ev_primary[5] = phy_tx_done;
	assign ev_alternate[5] = rssi_rise;

	always_comb
	begin
		for (int i = 0; i < `SIDE_CH_NUM_EVENTS; i++)
		begin
			if (event_src_e'(event_sel[i]) == src_alternate)
				ev_next[i] = ev_alternate[i];
			else
				ev_next[i] = ev_primary[i];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			events <= '0;
			rssi_above_q <= 1'b0;
		end
		else
		begin
			events <= ev_next;
			rssi_above_q <= rssi_above;
		end
	end

endmodule

`default_nettype wire

// File: verilog/side_ch_event_counter.sv
// event counter: six wrapping counters, one per event, each cleared by its own clear bit
`default_nettype none
`timescale 1ns/100ps

`include "side_ch_consts.svh"

module side_ch_event_counter
	import side_ch_event_pkg::*;
(
	input wire clk,
	input wire reset,

	// one pulse per counted event
	input wire [`SIDE_CH_NUM_EVENTS-1:0] events,

	// one cycle pulse from a host write to the counter address
	input wire [`SIDE_CH_NUM_EVENTS-1:0] clear,

	output counter_t [`SIDE_CH_NUM_EVENTS-1:0] counts
);

	counter_t [`SIDE_CH_NUM_EVENTS-1:0] counts_next;

	// clear takes priority over a coincident event
	always_comb
	begin
		for (int i = 0; i < `SIDE_CH_NUM_EVENTS; i++)
		begin
			if (clear[i])
				counts_next[i] = '0;
			else if (events[i])
				counts_next[i] = counts[i] + 1'b1;
			else
				counts_next[i] = counts[i];
		end
	end

	// natural wrap at the counter width
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			counts <= '0;
		end
		else
		begin
			counts <= counts_next;
		end
	end

endmodule

`default_nettype wire

// File: verilog/side_ch_reg_file.sv
// register file: configuration registers, counter clear pulses and registered readback
`default_nettype none
`timescale 1ns/100ps

`include "side_ch_consts.svh"

module side_ch_reg_file
	import side_ch_event_pkg::*;
	import side_ch_reg_pkg::*;
(
	input wire clk,
	input wire reset,

	// host bus
	input wire wr_strobe,
	input wire [`SIDE_CH_ADDR_WIDTH-1:0] wr_addr,
	input wire [`SIDE_CH_DATA_WIDTH-1:0] wr_data,
	input wire rd_strobe,
	input wire [`SIDE_CH_ADDR_WIDTH-1:0] rd_addr,
	input var counter_t [`SIDE_CH_NUM_EVENTS-1:0] counts,

	output logic [`SIDE_CH_NUM_EVENTS-1:0] event_sel,
	output logic [`SIDE_CH_MAC_WIDTH-1:0] addr2_target,
	output logic signed [`SIDE_CH_RSSI_WIDTH-1:0] rssi_th,
	output logic [`SIDE_CH_NUM_EVENTS-1:0] clear,
	output reg_data_t rd_data,
	output logic rd_valid
);

	reg_addr_e wr_op;
	reg_addr_e rd_op;
	reg_data_t event_sel_reg;
	reg_data_t addr2_lo_reg;
	logic [`SIDE_CH_MAC_WIDTH-`SIDE_CH_DATA_WIDTH-1:0] addr2_hi_reg;
	reg_data_t rssi_th_reg;
	logic [`SIDE_CH_NUM_EVENTS-1:0] clear_next;
	reg_data_t rd_mux;

	assign wr_op = reg_addr_e'(wr_addr);
	assign rd_op = reg_addr_e'(rd_addr);

	assign addr2_target = {addr2_hi_reg, addr2_lo_reg};
	assign rssi_th = rssi_th_reg[`SIDE_CH_RSSI_WIDTH-1:0];

	// one select bit per event, spaced by the stride
	always_comb
	begin
		for (int i = 0; i < `SIDE_CH_NUM_EVENTS; i++)
			event_sel[i] = event_sel_reg[i * `SIDE_CH_SEL_STRIDE];
	end

	always_comb
	begin
		clear_next = '0;
		for (int i = 0; i < `SIDE_CH_NUM_EVENTS; i++)
		begin
			if (wr_strobe && wr_addr == reg_counter0 + i)
				clear_next[i] = 1'b1;
		end
	end

	always_comb
	begin
		rd_mux = '0;
		case (rd_op)
			reg_addr2_target: rd_mux = addr2_lo_reg;
			reg_addr2_target_hi: rd_mux = {{(2 * `SIDE_CH_DATA_WIDTH - `SIDE_CH_MAC_WIDTH){1'b0}},
				addr2_hi_reg};
			reg_rssi_th: rd_mux = rssi_th_reg;
			reg_event_sel: rd_mux = event_sel_reg;
			default:
			begin
				// counters zero-extended, unmapped addresses stay 0
				for (int i = 0; i < `SIDE_CH_NUM_EVENTS; i++)
				begin
					if (rd_addr == reg_counter0 + i)
						rd_mux = {{(`SIDE_CH_DATA_WIDTH-`SIDE_CH_COUNTER_WIDTH){1'b0}}, counts[i]};
				end
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			event_sel_reg <= '0;
			addr2_lo_reg <= '0;
			addr2_hi_reg <= '0;
			rssi_th_reg <= '0;
			clear <= '0;
			rd_valid <= 1'b0;
		end
		else
		begin
			clear <= clear_next;
			rd_valid <= rd_strobe;
			if (wr_strobe)
			begin
				case (wr_op)
					reg_addr2_target: addr2_lo_reg <= wr_data;
					reg_addr2_target_hi: addr2_hi_reg <= wr_data[$bits(addr2_hi_reg)-1:0];
					reg_rssi_th: rssi_th_reg <= wr_data;
					reg_event_sel: event_sel_reg <= wr_data;
					default: ;
				endcase
			end
		end
	end

	// readback data, valid one cycle after the strobe
	always_ff @(posedge clk)
	begin
		if (rd_strobe)
			rd_data <= rd_mux;
	end

endmodule

`default_nettype wire

// File: verilog/side_ch_top.sv
// side channel statistics top: event decode, event counters and host register file
`default_nettype none
`timescale 1ns/100ps

`include "side_ch_consts.svh"

module side_ch_top
	import side_ch_event_pkg::*;
(
	input wire clk,
	input wire reset,

	// host register bus
	input wire wr_strobe,
	input wire [`SIDE_CH_ADDR_WIDTH-1:0] wr_addr,
	input wire [`SIDE_CH_DATA_WIDTH-1:0] wr_data,
	input wire rd_strobe,
	input wire [`SIDE_CH_ADDR_WIDTH-1:0] rd_addr,
	output wire [`SIDE_CH_DATA_WIDTH-1:0] rd_data,
	output wire rd_valid,

	// from rx
	input wire short_preamble_detected,
	input wire long_preamble_detected,
	input wire pkt_header_valid_strobe,
	input wire pkt_header_valid,
	input wire fcs_in_strobe,
	input wire fcs_ok,
	input wire [`SIDE_CH_DATA_WIDTH-1:0] fc_di,
	input wire [`SIDE_CH_MAC_WIDTH-1:0] addr2,
	input wire pkt_for_me,
	input wire signed [`SIDE_CH_RSSI_WIDTH-1:0] rssi_half_db,

	// from tx
	input wire phy_tx_start,
	input wire tx_pkt_need_ack,
	input wire phy_tx_done
);

	wire [`SIDE_CH_NUM_EVENTS-1:0] event_sel;
	wire [`SIDE_CH_MAC_WIDTH-1:0] addr2_target;
	wire signed [`SIDE_CH_RSSI_WIDTH-1:0] rssi_th;
	wire [`SIDE_CH_NUM_EVENTS-1:0] events;
	wire [`SIDE_CH_NUM_EVENTS-1:0] clear;
	counter_t [`SIDE_CH_NUM_EVENTS-1:0] counts;

	side_ch_event_decode event_decode_i (
		.clk(clk),
		.reset(reset),
		.short_preamble_detected(short_preamble_detected),
		.long_preamble_detected(long_preamble_detected),
		.pkt_header_valid_strobe(pkt_header_valid_strobe),
		.pkt_header_valid(pkt_header_valid),
		.fcs_in_strobe(fcs_in_strobe),
		.fcs_ok(fcs_ok),
		.fc_di(fc_di),
		.addr2(addr2),
		.pkt_for_me(pkt_for_me),
		.rssi_half_db(rssi_half_db),
		.phy_tx_start(phy_tx_start),
		.tx_pkt_need_ack(tx_pkt_need_ack),
		.phy_tx_done(phy_tx_done),
		.event_sel(event_sel),
		.addr2_target(addr2_target),
		.rssi_th(rssi_th),
		.events(events)
	);

	side_ch_event_counter event_counter_i (
		.clk(clk),
		.reset(reset),
		.events(events),
		.clear(clear),
		.counts(counts)
	);

	side_ch_reg_file reg_file_i (
		.clk(clk),
		.reset(reset),
		.wr_strobe(wr_strobe),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_strobe(rd_strobe),
		.rd_addr(rd_addr),
		.counts(counts),
		.event_sel(event_sel),
		.addr2_target(addr2_target),
		.rssi_th(rssi_th),
		.clear(clear),
		.rd_data(rd_data),
		.rd_valid(rd_valid)
	);

endmodule

`default_nettype wire

// File: testbench/side_ch_chk.sv
// side channel checks: read handshake timing, rd_valid after reset and counter clear
`default_nettype none
`timescale 1ns/100ps

`include "side_ch_consts.svh"

module side_ch_chk
	import side_ch_event_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire rd_strobe,
	input wire rd_valid,
	input wire [`SIDE_CH_NUM_EVENTS-1:0] clear,
	input var counter_t [`SIDE_CH_NUM_EVENTS-1:0] counts
);

	int assert_errors = 0;

	// readback valid exactly one cycle after the strobe
	rd_valid_follows: assert property (@(posedge clk) disable iff (reset)
		rd_valid == $past(rd_strobe))
	else
	begin
		$error("rd_valid does not follow rd_strobe by one cycle");
		assert_errors++;
	end

	rd_valid_after_reset: assert property (@(posedge clk) reset |=> !rd_valid)
	else
	begin
		$error("rd_valid high after reset");
		assert_errors++;
	end

	for (genvar i = 0; i < `SIDE_CH_NUM_EVENTS; i++)
	begin : clear_checks
		counter_cleared: assert property (@(posedge clk) disable iff (reset)
			clear[i] |=> counts[i] == '0)
		else
		begin
			$error("counter %0d not zero after clear", i);
			assert_errors++;
		end
	end

endmodule

bind side_ch_top side_ch_chk chk_i (
	.clk(clk),
	.reset(reset),
	.rd_strobe(rd_strobe),
	.rd_valid(rd_valid),
	.clear(clear),
	.counts(counts)
);

`default_nettype wire

// File: testbench/side_ch_tb.sv
// side channel testbench: random status stimulus, counter model and bus readback checks
`default_nettype none
`timescale 1ns/100ps

`include "side_ch_consts.svh"

module side_ch_tb
	import side_ch_event_pkg::*;
	import side_ch_reg_pkg::*;
();

	localparam int RAND_CYCLES = 300;
	localparam int WRAP_PULSES = 70000;
	// reads, writes and settling, rounded up
	localparam int BUS_CYCLES = 400;
	localparam int STIM_CYCLES = 2 * RAND_CYCLES + WRAP_PULSES + BUS_CYCLES;
	localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + 100;
	// select bits 0, 4, 8, 12, 16 and 20
	localparam reg_data_t ALL_ALTERNATE = 32'h0011_1111;

	logic clk;
	logic reset;
	logic wr_strobe;
	logic [`SIDE_CH_ADDR_WIDTH-1:0] wr_addr;
	reg_data_t wr_data;
	logic rd_strobe;
	logic [`SIDE_CH_ADDR_WIDTH-1:0] rd_addr;
	wire [`SIDE_CH_DATA_WIDTH-1:0] rd_data;
	wire rd_valid;
	logic short_preamble_detected;
	logic long_preamble_detected;
	logic pkt_header_valid_strobe;
	logic pkt_header_valid;
	logic fcs_in_strobe;
	logic fcs_ok;
	logic [`SIDE_CH_DATA_WIDTH-1:0] fc_di;
	logic [`SIDE_CH_MAC_WIDTH-1:0] addr2;
	logic pkt_for_me;
	logic signed [`SIDE_CH_RSSI_WIDTH-1:0] rssi_half_db;
	logic phy_tx_start;
	logic tx_pkt_need_ack;
	logic phy_tx_done;

	// reference model state
	counter_t m_counts [`SIDE_CH_NUM_EVENTS];
	logic [`SIDE_CH_NUM_EVENTS-1:0] m_ev;
	logic [`SIDE_CH_NUM_EVENTS-1:0] m_clr;
	reg_data_t m_sel;
	reg_data_t m_addr2_lo;
	reg_data_t m_addr2_hi;
	reg_data_t m_rssi_th;
	logic m_rssi_above;

	reg_data_t exp_q [$];
	logic [`SIDE_CH_ADDR_WIDTH-1:0] addr_q [$];
	string name_q [$];
	string cur_test;
	int cycle_count = 0;
	logic [`SIDE_CH_MAC_WIDTH-1:0] drv_addr2;
	logic signed [`SIDE_CH_RSSI_WIDTH-1:0] drv_th;

	side_ch_top UUT (
		.clk(clk),
		.reset(reset),
		.wr_strobe(wr_strobe),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_strobe(rd_strobe),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.rd_valid(rd_valid),
		.short_preamble_detected(short_preamble_detected),
		.long_preamble_detected(long_preamble_detected),
		.pkt_header_valid_strobe(pkt_header_valid_strobe),
		.pkt_header_valid(pkt_header_valid),
		.fcs_in_strobe(fcs_in_strobe),
		.fcs_ok(fcs_ok),
		.fc_di(fc_di),
		.addr2(addr2),
		.pkt_for_me(pkt_for_me),
		.rssi_half_db(rssi_half_db),
		.phy_tx_start(phy_tx_start),
		.tx_pkt_need_ack(tx_pkt_need_ack),
		.phy_tx_done(phy_tx_done)
	);

	always #2 clk = ~clk;

	// expected event bits for the stimulus now on the inputs
	function automatic logic [`SIDE_CH_NUM_EVENTS-1:0] exp_events(input logic rssi_prev);
		logic [`SIDE_CH_NUM_EVENTS-1:0] prim;
		logic [`SIDE_CH_NUM_EVENTS-1:0] alt;
		logic [`SIDE_CH_NUM_EVENTS-1:0] ev;
		logic good_fcs;
		logic data_frame;
		logic target_match;
		logic rssi_up;
		good_fcs = fcs_in_strobe && fcs_ok;
		data_frame = (frame_type_e'(fc_di[`SIDE_CH_FC_TYPE_LSB +: 2]) == frame_data);
		target_match = (addr2 == {m_addr2_hi[15:0], m_addr2_lo});
		rssi_up = (rssi_half_db > $signed(m_rssi_th[`SIDE_CH_RSSI_WIDTH-1:0])) && !rssi_prev;
		prim = {phy_tx_done, phy_tx_start, good_fcs && data_frame && target_match, good_fcs,
			pkt_header_valid_strobe && pkt_header_valid, short_preamble_detected};
		alt = {rssi_up, phy_tx_start && tx_pkt_need_ack, good_fcs && pkt_for_me,
			fcs_in_strobe && !fcs_ok, pkt_header_valid_strobe && !pkt_header_valid,
			long_preamble_detected};
		for (int i = 0; i < `SIDE_CH_NUM_EVENTS; i++)
			ev[i] = m_sel[i * `SIDE_CH_SEL_STRIDE] ? alt[i] : prim[i];
		return ev;
	endfunction

	function automatic reg_data_t exp_read(input logic [`SIDE_CH_ADDR_WIDTH-1:0] addr);
		reg_data_t value;
		value = '0;
		case (addr)
			reg_addr2_target: value = m_addr2_lo;
			reg_addr2_target_hi: value = m_addr2_hi;
			reg_rssi_th: value = m_rssi_th;
			reg_event_sel: value = m_sel;
			default:
			begin
				if (addr >= reg_counter0)
					value = m_counts[addr - reg_counter0];
			end
		endcase
		return value;
	endfunction

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_counter(input string test, input counter_t expected, input counter_t actual);
		if (actual !== expected)
			fail_run($sformatf("[FAIL] %s: expected %0d, actual %0d", test, expected, actual));
	endtask

	task automatic check_reg(input string test, input reg_data_t expected, input reg_data_t actual);
		if (actual !== expected)
			fail_run($sformatf("[FAIL] %s: expected %h, actual %h", test, expected, actual));
	endtask

	task automatic idle_status();
		short_preamble_detected = 1'b0;
		long_preamble_detected = 1'b0;
		pkt_header_valid_strobe = 1'b0;
		pkt_header_valid = 1'b0;
		fcs_in_strobe = 1'b0;
		fcs_ok = 1'b0;
		fc_di = '0;
		addr2 = '0;
		pkt_for_me = 1'b0;
		rssi_half_db = '0;
		phy_tx_start = 1'b0;
		tx_pkt_need_ack = 1'b0;
		phy_tx_done = 1'b0;
	endtask

	task automatic bus_write(input logic [`SIDE_CH_ADDR_WIDTH-1:0] addr, input reg_data_t data);
		@(negedge clk);
		wr_strobe = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(negedge clk);
		wr_strobe = 1'b0;
	endtask

	task automatic bus_read(input logic [`SIDE_CH_ADDR_WIDTH-1:0] addr);
		@(negedge clk);
		rd_strobe = 1'b1;
		rd_addr = addr;
		@(negedge clk);
		rd_strobe = 1'b0;
	endtask

	task automatic read_counters();
		for (int i = 0; i < `SIDE_CH_NUM_EVENTS; i++)
			bus_read(reg_counter0 + i);
	endtask

	task automatic read_config();
		bus_read(reg_addr2_target);
		bus_read(reg_addr2_target_hi);
		bus_read(reg_rssi_th);
		bus_read(reg_event_sel);
	endtask

	// addr2 hits the target about half the time, rssi wanders around the threshold
	task automatic random_status(input int cycles);
		int offset;
		repeat (cycles)
		begin
			@(negedge clk);
			short_preamble_detected = $urandom_range(0, 1);
			long_preamble_detected = $urandom_range(0, 1);
			pkt_header_valid_strobe = $urandom_range(0, 1);
			pkt_header_valid = $urandom_range(0, 1);
			fcs_in_strobe = $urandom_range(0, 1);
			fcs_ok = $urandom_range(0, 1);
			fc_di = $urandom;
			addr2 = ($urandom_range(0, 1) != 0) ? drv_addr2 : {$urandom, $urandom};
			pkt_for_me = $urandom_range(0, 1);
			offset = $urandom_range(0, 15);
			rssi_half_db = drv_th + offset - 8;
			phy_tx_start = $urandom_range(0, 1);
			tx_pkt_need_ack = $urandom_range(0, 1);
			phy_tx_done = $urandom_range(0, 1);
		end
		@(negedge clk);
		idle_status();
	endtask

	// cycle model, event at edge k counts at k+1, clear wins
	always @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `SIDE_CH_NUM_EVENTS; i++)
				m_counts[i] = '0;
			m_ev = '0;
			m_clr = '0;
			m_sel = '0;
			m_addr2_lo = '0;
			m_addr2_hi = '0;
			m_rssi_th = '0;
			m_rssi_above = 1'b0;
		end
		else
		begin
			if (rd_strobe)
			begin
				exp_q.push_back(exp_read(rd_addr));
				addr_q.push_back(rd_addr);
				name_q.push_back(cur_test);
			end
			for (int i = 0; i < `SIDE_CH_NUM_EVENTS; i++)
			begin
				if (m_clr[i])
					m_counts[i] = '0;
				else if (m_ev[i])
					m_counts[i] = m_counts[i] + 1'b1;
			end
			m_ev = exp_events(m_rssi_above);
			m_rssi_above = (rssi_half_db > $signed(m_rssi_th[`SIDE_CH_RSSI_WIDTH-1:0]));
			m_clr = '0;
			if (wr_strobe)
			begin
				if (wr_addr >= reg_counter0)
					m_clr[wr_addr - reg_counter0] = 1'b1;
				case (wr_addr)
					reg_addr2_target: m_addr2_lo = wr_data;
					reg_addr2_target_hi: m_addr2_hi = {16'h0, wr_data[15:0]};
					reg_rssi_th: m_rssi_th = wr_data;
					reg_event_sel: m_sel = wr_data;
					default: ;
				endcase
			end
		end
	end

	// readback compare, one cycle after each strobe
	always @(negedge clk)
	begin
		if (UUT.chk_i.assert_errors != 0)
			fail_run("a bound assertion on the DUT failed");
		if (exp_q.size() != 0)
		begin
			if (rd_valid !== 1'b1)
				fail_run("rd_valid did not rise one cycle after rd_strobe");
			if (addr_q[0] >= reg_counter0)
			begin
				check_counter($sformatf("%s reg %0d", name_q[0], addr_q[0]), exp_q[0][15:0],
					rd_data[15:0]);
				check_reg($sformatf("%s reg %0d upper", name_q[0], addr_q[0]), '0, rd_data >> 16);
			end
			else
				check_reg($sformatf("%s reg %0d", name_q[0], addr_q[0]), exp_q[0], rd_data);
			void'(exp_q.pop_front());
			void'(addr_q.pop_front());
			void'(name_q.pop_front());
		end
		else if (rd_valid === 1'b1)
			fail_run("rd_valid rose without a read strobe");
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
			fail_run("timeout: the run went past its cycle limit");
	end

	initial
	begin
		void'($urandom(44430));
		clk = 1'b0;
		reset = 1'b1;
		wr_strobe = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		rd_strobe = 1'b0;
		rd_addr = '0;
		drv_addr2 = '0;
		drv_th = '0;
		cur_test = "reset values";
		idle_status();
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		read_counters();
		read_config();

		// nonzero target so that the address match can both hit and miss
		cur_test = "primary random";
		drv_addr2 = {$urandom, $urandom};
		bus_write(reg_addr2_target, drv_addr2[31:0]);
		bus_write(reg_addr2_target_hi, drv_addr2[47:32]);
		random_status(RAND_CYCLES);
		read_counters();

		cur_test = "alternate random";
		drv_addr2 = {$urandom, $urandom};
		drv_th = $urandom_range(0, 200);
		bus_write(reg_addr2_target, drv_addr2[31:0]);
		bus_write(reg_addr2_target_hi, drv_addr2[47:32]);
		bus_write(reg_rssi_th, drv_th);
		bus_write(reg_event_sel, ALL_ALTERNATE);
		random_status(RAND_CYCLES);
		read_counters();
		read_config();

		cur_test = "config readback";
		drv_addr2 = {$urandom, $urandom};
		bus_write(reg_addr2_target, drv_addr2[31:0]);
		bus_write(reg_addr2_target_hi, $urandom);
		bus_write(reg_rssi_th, $urandom);
		bus_write(reg_event_sel, $urandom);
		read_config();

		// every event fires each cycle while counters are cleared
		cur_test = "clear during events";
		bus_write(reg_addr2_target_hi, drv_addr2[47:32]);
		bus_write(reg_event_sel, '0);
		short_preamble_detected = 1'b1;
		pkt_header_valid_strobe = 1'b1;
		pkt_header_valid = 1'b1;
		fcs_in_strobe = 1'b1;
		fcs_ok = 1'b1;
		fc_di = 32'(frame_data) << `SIDE_CH_FC_TYPE_LSB;
		addr2 = drv_addr2;
		phy_tx_start = 1'b1;
		phy_tx_done = 1'b1;
		for (int i = 0; i < `SIDE_CH_NUM_EVENTS; i++)
		begin
			bus_write(reg_counter0 + i, $urandom);
			read_counters();
		end
		@(negedge clk);
		idle_status();
		read_counters();

		cur_test = "counter wrap";
		bus_write(reg_counter5, '0);
		repeat (WRAP_PULSES)
		begin
			@(negedge clk);
			phy_tx_done = 1'b1;
		end
		@(negedge clk);
		phy_tx_done = 1'b0;
		bus_read(reg_counter5);
		check_counter("counter wrap", counter_t'(WRAP_PULSES % 65536), rd_data[15:0]);
		repeat (2) @(negedge clk);

		if (UUT.chk_i.assert_errors != 0)
			fail_run("a bound assertion on the DUT failed");
		else
		begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verilog
verilog/side_ch_event_pkg.sv
verilog/side_ch_reg_pkg.sv
verilog/side_ch_event_decode.sv
verilog/side_ch_event_counter.sv
verilog/side_ch_reg_file.sv
verilog/side_ch_top.sv
testbench/side_ch_chk.sv
testbench/side_ch_tb.sv
